/* burst_buffer.f */
src/burst_buffer_pkg.sv
src/occupancy_shifter.sv
src/onehot_counter.sv
src/onehot_mux.sv
src/small_fifo.sv
src/burst_reader.sv
src/burst_buffer.sv
tb/tb_clock_gen.sv
tb/burst_buffer_assertions.sv
tb/burst_buffer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module burst_buffer_tb -f burst_buffer.f &&
./obj_dir/Vburst_buffer_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* src/burst_buffer.sv */
// Burst buffer top level
`timescale 1ns/1ns
`default_nettype none

module burst_buffer
#(
	parameter int DEPTH = burst_buffer_pkg::DEFAULT_DEPTH,
	parameter int BURST_LEN = burst_buffer_pkg::DEFAULT_BURST_LEN
)
(
	input wire logic clk,
	input wire logic rstnn,
	input wire logic enable,
	input wire logic clear,
	input wire logic drain_en,
	input wire logic in_write,
	input wire burst_buffer_pkg::data_t in_data,
	output logic in_ready,
	output logic empty,
	output burst_buffer_pkg::burst_out_t out
);

	import burst_buffer_pkg::*;

	// FIFO to reader
	logic [DEPTH-1:0] level;
	data_t rdata;
	// Reader to FIFO
	logic pop;

	// Entry storage
	small_fifo #(
		.DEPTH(DEPTH)
	) i_small_fifo (
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.clear(clear),
		.write(in_write),
		.pop(pop),
		.wdata(in_data),
		.rdata(rdata),
		.level(level),
		.in_ready(in_ready),
		.empty(empty)
	);

	// Burst detection and drain
	burst_reader #(
		.DEPTH(DEPTH),
		.BURST_LEN(BURST_LEN)
	) i_burst_reader (
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.clear(clear),
		.drain_en(drain_en),
		.level(level),
		.rdata(rdata),
		.pop(pop),
		.out(out)
	);

endmodule

`default_nettype wire

/* src/burst_buffer_pkg.sv */
// Burst buffer shared types
`default_nettype none

package burst_buffer_pkg;

	// ********************
	// Widths and defaults
	// ********************

	// Width of one stored word
	localparam int BW_DATA = 8;

	// Default FIFO depth
	localparam int DEFAULT_DEPTH = 8;
	// Default burst length, never above the depth
	localparam int DEFAULT_BURST_LEN = 4;

	// FIFO word
	typedef logic [BW_DATA-1:0] data_t;

	// ********************
	// Output beat
	// ********************

	// One beat toward the consumer
	typedef struct packed {
		// Entry popped this cycle
		logic valid;
		// Final beat of the burst
		logic last;
		// Popped word
		data_t data;
	} burst_out_t;

	// Burst reader FSM states
	typedef enum logic {
		IDLE,
		DRAIN
	} burst_state_e;

endpackage

`default_nettype wire

/* src/burst_reader.sv */
// Burst drain controller
`timescale 1ns/1ns
`default_nettype none

module burst_reader
#(
	parameter int DEPTH = burst_buffer_pkg::DEFAULT_DEPTH,
	parameter int BURST_LEN = burst_buffer_pkg::DEFAULT_BURST_LEN
)
(
	input wire logic clk,
	input wire logic rstnn,
	input wire logic enable,
	input wire logic clear,
	input wire logic drain_en,
	input wire logic [DEPTH-1:0] level,
	input wire burst_buffer_pkg::data_t rdata,
	output logic pop,
	output burst_buffer_pkg::burst_out_t out
);

	import burst_buffer_pkg::*;

	// Beat index within a burst
	localparam int BW_BEAT = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
	typedef logic [BW_BEAT-1:0] beat_t;
	localparam beat_t LAST_BEAT = beat_t'(BURST_LEN - 1);

	burst_state_e state;
	beat_t beat_cnt;

	// Current beat closes the burst
	logic last_beat;

	// ********************
	// FSM
	// ********************

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
		begin
			state <= IDLE;
			beat_cnt <= '0;
		end
		else if (enable)
		begin
			// Clear aborts a running burst
			if (clear)
			begin
				state <= IDLE;
				beat_cnt <= '0;
			end
			else
			begin
				case (state)
					IDLE:
					begin
						// A whole burst must be stored before starting
						if (drain_en && level[BURST_LEN-1])
							state <= DRAIN;
						beat_cnt <= '0;
					end
					DRAIN:
					begin
						// drain_en is ignored once started
						if (last_beat)
						begin
							state <= IDLE;
							beat_cnt <= '0;
						end
						else
							beat_cnt <= beat_cnt + beat_t'(1);
					end
					default:
						state <= IDLE;
				endcase
			end
		end
	end

	// Pop every DRAIN cycle, frozen while disabled or clearing
	assign pop = (state == DRAIN) & enable & ~clear;
	assign last_beat = (beat_cnt == LAST_BEAT);

	// Beat to the consumer, data straight from the FIFO head
	always_comb
	begin
		out.valid = pop;
		out.last = pop & last_beat;
		out.data = rdata;
	end

endmodule

`default_nettype wire

/* src/occupancy_shifter.sv */
// Thermometer occupancy register
`timescale 1ns/1ns
`default_nettype none

module occupancy_shifter
#(
	parameter int DEPTH = burst_buffer_pkg::DEFAULT_DEPTH
)
(
	input wire logic clk,
	input wire logic rstnn,
	input wire logic enable,
	input wire logic clear,
	input wire logic grow,
	input wire logic shrink,
	output logic [DEPTH-1:0] level,
	output logic full,
	output logic empty
);

	// Bit k set means more than k entries stored
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			level <= '0;
		else if (enable)
		begin
			if (clear)
				level <= '0;
			// One more entry, shift a one in at the low end
			else if (grow && !shrink)
				level <= (level << 1) | DEPTH'(1);
			// One entry less
			else if (shrink && !grow)
				level <= level >> 1;
			// Both or neither, occupancy unchanged
		end
	end

	// Top bit set only when every slot is taken
	assign full = level[DEPTH-1];

	// Bottom bit clear means nothing stored
	assign empty = ~level[0];

endmodule

`default_nettype wire

/* src/onehot_counter.sv */
// Circular one-hot pointer
`timescale 1ns/1ns
`default_nettype none

module onehot_counter
#(
	parameter int DEPTH = burst_buffer_pkg::DEFAULT_DEPTH
)
(
	input wire logic clk,
	input wire logic rstnn,
	input wire logic enable,
	input wire logic clear,
	input wire logic step,
	output logic [DEPTH-1:0] position
);

	// Exactly one bit set at all times
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			position <= DEPTH'(1);
		else if (enable)
		begin
			// Back to slot 0
			if (clear)
				position <= DEPTH'(1);
			// Rotate left, top bit wraps to bit 0
			else if (step)
				position <= (position << 1) | (position >> (DEPTH-1));
		end
	end

endmodule

`default_nettype wire

/* src/onehot_mux.sv */
// One-hot select multiplexer
`timescale 1ns/1ns
`default_nettype none

module onehot_mux
#(
	parameter int DEPTH = burst_buffer_pkg::DEFAULT_DEPTH
)
(
	input wire burst_buffer_pkg::data_t entries [DEPTH],
	input wire logic [DEPTH-1:0] select,
	output burst_buffer_pkg::data_t data_out
);

	import burst_buffer_pkg::*;

	// AND-OR tree, select is one-hot so no priority
	always_comb
	begin
		data_out = '0;
		for (int i = 0; i < DEPTH; i++)
			data_out = data_out | (entries[i] & {BW_DATA{select[i]}});
	end

endmodule

`default_nettype wire

/* src/small_fifo.sv */
// Small one-hot FIFO
`timescale 1ns/1ns
`default_nettype none

module small_fifo
#(
	parameter int DEPTH = burst_buffer_pkg::DEFAULT_DEPTH
)
(
	input wire logic clk,
	input wire logic rstnn,
	input wire logic enable,
	input wire logic clear,
	input wire logic write,
	input wire logic pop,
	input wire burst_buffer_pkg::data_t wdata,
	output burst_buffer_pkg::data_t rdata,
	output logic [DEPTH-1:0] level,
	output logic in_ready,
	output logic empty
);

	import burst_buffer_pkg::*;

	// Storage slots
	data_t entries [DEPTH];

	// One-hot pointers
	logic [DEPTH-1:0] wr_ptr;
	logic [DEPTH-1:0] rd_ptr;

	// All slots taken
	logic full;

	// Strobes that really move data
	logic write_acc;
	logic pop_acc;

	// ********************
	// Accept logic
	// ********************

	// No space while full, none at all during clear
	assign in_ready = ~full & ~clear;
	assign write_acc = write & in_ready;
	// Pop on empty is ignored
	assign pop_acc = pop & ~empty;

	// Occupancy in thermometer code
	occupancy_shifter #(
		.DEPTH(DEPTH)
	) i_occupancy (
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.clear(clear),
		.grow(write_acc),
		.shrink(pop_acc),
		.level(level),
		.full(full),
		.empty(empty)
	);

	// Write pointer
	onehot_counter #(
		.DEPTH(DEPTH)
	) i_wr_ptr (
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.clear(clear),
		.step(write_acc),
		.position(wr_ptr)
	);

	// Read pointer
	onehot_counter #(
		.DEPTH(DEPTH)
	) i_rd_ptr (
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.clear(clear),
		.step(pop_acc),
		.position(rd_ptr)
	);

	// ********************
	// Storage
	// ********************

	// Only the slot under the write pointer loads
	always_ff @(posedge clk)
	begin
		if (enable && write_acc)
			for (int i = 0; i < DEPTH; i++)
				if (wr_ptr[i])
					entries[i] <= wdata;
	end

	// Head entry, no delay
	onehot_mux #(
		.DEPTH(DEPTH)
	) i_head_mux (
		.entries(entries),
		.select(rd_ptr),
		.data_out(rdata)
	);

endmodule

`default_nettype wire

/* tb/burst_buffer_assertions.sv */
// Burst buffer port assertions
`timescale 1ns/1ns
`default_nettype none

module burst_buffer_assertions
#(
	parameter int DEPTH = burst_buffer_pkg::DEFAULT_DEPTH,
	parameter int BURST_LEN = burst_buffer_pkg::DEFAULT_BURST_LEN
)
(
	input wire logic clk,
	input wire logic rstnn,
	input wire logic enable,
	input wire logic clear,
	input wire logic in_write,
	input wire logic in_ready,
	input wire logic empty,
	input wire burst_buffer_pkg::burst_out_t out
);

	import burst_buffer_pkg::*;

	// Entries held, counted from the ports
	int occupancy;
	// Beats already seen in the current burst
	int beat_pos;
	logic write_acc;

	assign write_acc = enable & in_write & in_ready;

	// ********************
	// Occupancy tracking
	// ********************

	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			occupancy <= 0;
		else if (enable)
		begin
			if (clear)
				occupancy <= 0;
			// Accepted writes add, beats remove
			else
				occupancy <= occupancy + int'(write_acc) - int'(out.valid);
		end
	end

	// Position within the burst, restarts on clear
	always_ff @(posedge clk or negedge rstnn)
	begin
		if (!rstnn)
			beat_pos <= 0;
		else if (enable)
		begin
			if (clear)
				beat_pos <= 0;
			else if (out.valid)
				beat_pos <= (beat_pos + 1) % BURST_LEN;
		end
	end

	// Last is a real beat and closes a full burst
	a_last_final_beat: assert property (@(posedge clk) disable iff (!rstnn)
		out.last |-> (out.valid && beat_pos == BURST_LEN - 1))
		else $error("out.last high off the final beat, position %0d", beat_pos);

	// Nothing pops from an empty FIFO
	a_valid_not_empty: assert property (@(posedge clk) disable iff (!rstnn)
		out.valid |-> !empty)
		else $error("out.valid high while FIFO empty");

	// Outside clear, back-pressure only when every slot is taken
	a_ready_low_full: assert property (@(posedge clk) disable iff (!rstnn)
		(!in_ready && !clear) |-> (occupancy == DEPTH))
		else $error("in_ready low with free slots, occupancy %0d", occupancy);

endmodule

`default_nettype wire

/* tb/burst_buffer_tb.sv */
// Burst buffer testbench
`timescale 1ns/1ns
`default_nettype none

module burst_buffer_tb;

	import burst_buffer_pkg::*;

	localparam int DEPTH = DEFAULT_DEPTH;
	localparam int BURST_LEN = DEFAULT_BURST_LEN;
	localparam logic [31:0] SEED = 32'h54410b8f;
	// Rough cycle count of all tests together
	localparam int TEST_CYCLES = 320;
	localparam int TIMEOUT_NS = TEST_CYCLES * 8 * 2;

	logic clk;
	logic rstnn;
	logic enable;
	logic clear;
	logic drain_en;
	logic in_write;
	data_t in_data;
	logic in_ready;
	logic empty;
	burst_out_t dut_out;

	// Reference model state
	data_t ref_q[$];
	int beat_idx;
	int beat_count;
	logic error_seen;
	logic [31:0] lfsr;

	tb_clock_gen #(
		.PERIOD_NS(8)
	) i_clock_gen (
		.clk(clk)
	);

	burst_buffer #(
		.DEPTH(DEPTH),
		.BURST_LEN(BURST_LEN)
	) i_burst_buffer (
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.clear(clear),
		.drain_en(drain_en),
		.in_write(in_write),
		.in_data(in_data),
		.in_ready(in_ready),
		.empty(empty),
		.out(dut_out)
	);

	bind burst_buffer burst_buffer_assertions #(
		.DEPTH(DEPTH),
		.BURST_LEN(BURST_LEN)
	) i_assertions (
		.clk(clk),
		.rstnn(rstnn),
		.enable(enable),
		.clear(clear),
		.in_write(in_write),
		.in_ready(in_ready),
		.empty(empty),
		.out(out)
	);

	// ********************
	// Helpers
	// ********************

	task automatic report_failure(input string what);
		$display("%s", what);
		error_seen = 1'b1;
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			report_failure($sformatf("CHECK FAILED: %s actual 0x%0h expected 0x%0h",
				name, actual, expected));
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic random_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		return b;
	endfunction

	function automatic data_t random_byte();
		data_t value;
		value = '0;
		for (int i = 0; i < 8; i++)
			value = {value[6:0], random_bit()};
		return value;
	endfunction

	// Every task resumes 1 ns after a rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic write_byte(input data_t d);
		in_write = 1'b1;
		in_data = d;
		next_cycle();
		in_write = 1'b0;
	endtask

	task automatic wait_beats(input int target);
		while (beat_count < target)
			next_cycle();
	endtask

	// ********************
	// Scoreboard
	// ********************

	// Outputs settle well before the falling edge
	always @(negedge clk)
	begin
		if (rstnn && enable)
		begin
			if (clear)
			begin
				// Clear flushes the FIFO and aborts the burst
				ref_q.delete();
				beat_idx = 0;
			end
			else
			begin
				if (dut_out.valid)
				begin
					if (ref_q.size() == 0)
						report_failure("Beat seen with no entry in the reference queue");
					// Start only with a whole burst stored
					if (beat_idx == 0 && ref_q.size() < BURST_LEN)
						report_failure("Burst started with fewer than four entries stored");
					check("out.data", 32'(dut_out.data), 32'(ref_q.pop_front()));
					check("out.last", 32'(dut_out.last), 32'(beat_idx == BURST_LEN - 1));
					beat_idx = (beat_idx + 1) % BURST_LEN;
					beat_count++;
				end
				// A started burst runs without a gap
				else if (beat_idx != 0)
					check("out.valid", 32'(dut_out.valid), 1);
				if (in_write && in_ready)
					ref_q.push_back(in_data);
			end
		end
	end

	// ********************
	// Tests
	// ********************

	task automatic test_reset_state();
		@(negedge clk);
		check("in_ready", 32'(in_ready), 1);
		check("empty", 32'(empty), 1);
		check("out.valid", 32'(dut_out.valid), 0);
		check("out.last", 32'(dut_out.last), 0);
		next_cycle();
	endtask

	task automatic test_fill_without_drain();
		int start;
		start = beat_count;
		drain_en = 1'b0;
		for (int i = 0; i < DEPTH; i++)
			write_byte(random_byte());
		@(negedge clk);
		check("in_ready", 32'(in_ready), 0);
		check("empty", 32'(empty), 0);
		next_cycle();
		// Ninth byte is dropped
		write_byte(random_byte());
		idle_cycles(3);
		check("queue size", 32'(ref_q.size()), DEPTH);
		check("beat count", 32'(beat_count), 32'(start));
	endtask

	task automatic test_drain_two_bursts();
		int start;
		start = beat_count;
		drain_en = 1'b1;
		wait_beats(start + 2 * BURST_LEN);
		idle_cycles(4);
		@(negedge clk);
		check("beat count", 32'(beat_count), 32'(start + 2 * BURST_LEN));
		check("empty", 32'(empty), 1);
		next_cycle();
	endtask

	task automatic test_burst_start_timing();
		int start;
		start = beat_count;
		drain_en = 1'b1;
		for (int i = 0; i < BURST_LEN - 1; i++)
			write_byte(random_byte());
		idle_cycles(4);
		check("beat count", 32'(beat_count), 32'(start));
		write_byte(random_byte());
		// Level updates at this edge, reader moves to DRAIN at the next
		@(negedge clk);
		check("out.valid", 32'(dut_out.valid), 0);
		next_cycle();
		@(negedge clk);
		check("out.valid", 32'(dut_out.valid), 1);
		next_cycle();
		wait_beats(start + BURST_LEN);
		idle_cycles(2);
		check("empty", 32'(empty), 1);
	endtask

	task automatic test_clear_mid_burst();
		int start;
		start = beat_count;
		drain_en = 1'b0;
		for (int i = 0; i < 6; i++)
			write_byte(random_byte());
		drain_en = 1'b1;
		wait_beats(start + 2);
		// Abort on the third beat
		clear = 1'b1;
		@(negedge clk);
		check("in_ready", 32'(in_ready), 0);
		check("out.valid", 32'(dut_out.valid), 0);
		next_cycle();
		clear = 1'b0;
		drain_en = 1'b0;
		@(negedge clk);
		check("empty", 32'(empty), 1);
		check("in_ready", 32'(in_ready), 1);
		check("out.valid", 32'(dut_out.valid), 0);
		check("out.last", 32'(dut_out.last), 0);
		idle_cycles(3);
		check("beat count", 32'(beat_count), 32'(start + 2));
		// Fresh data after the clear
		drain_en = 1'b1;
		for (int i = 0; i < BURST_LEN; i++)
			write_byte(random_byte());
		wait_beats(start + 2 + BURST_LEN);
		idle_cycles(2);
		check("empty", 32'(empty), 1);
	endtask

	task automatic test_random_traffic();
		int start;
		start = beat_count;
		for (int i = 0; i < 200; i++)
		begin
			in_write = random_bit();
			in_data = random_byte();
			drain_en = random_bit();
			next_cycle();
		end
		in_write = 1'b0;
		drain_en = 1'b1;
		idle_cycles(12);
		@(negedge clk);
		if (beat_count == start)
			report_failure("No beat appeared during random traffic");
		// Only a partial burst may stay behind
		if (ref_q.size() >= BURST_LEN)
			report_failure("Full burst left undrained after random traffic");
		check("empty", 32'(empty), 32'(ref_q.size() == 0));
		next_cycle();
	endtask

	// ********************
	// Main sequence
	// ********************

	initial
	begin
		rstnn = 1'b0;
		enable = 1'b1;
		clear = 1'b0;
		drain_en = 1'b0;
		in_write = 1'b0;
		in_data = '0;
		beat_idx = 0;
		beat_count = 0;
		error_seen = 1'b0;
		lfsr = SEED;
		repeat (5) @(posedge clk);
		#1;
		rstnn = 1'b1;
		test_reset_state();
		test_fill_without_drain();
		test_drain_two_bursts();
		test_burst_start_timing();
		test_clear_mid_burst();
		test_random_traffic();
		if (!error_seen)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		report_failure($sformatf("Timeout, run still going after %0d ns", TIMEOUT_NS));
	end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// Testbench clock source
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
#(
	parameter int PERIOD_NS = 8
)
(
	output logic clk
);

	// Free running, starts low
	initial
	begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire
